//--- cam_params.svh
`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

// rate window length in cam_port cycles, one second at 84 MHz
`define CAM_RATE_WINDOW_DFLT 32'd84000000

// width of one latched rate count
`define CAM_RATE_CNT_W 16

// apb byte offsets of the status block
// window length, read/write
`define CAM_ADDR_WINDOW 8'h00
// camera frames per window, read only
`define CAM_ADDR_FRAME_RATE 8'h04
// encoder frames per window, read only
`define CAM_ADDR_JPEG_RATE 8'h08
// sequencer state and sticky new bits, read only
`define CAM_ADDR_STATUS 8'h0C

`endif

//--- bringup_pkg.sv
package bringup_pkg;

    // power-up phases, in the order they are walked
    typedef enum logic [2:0] {
        IDLE,
        // mac owns the shared pins here
        MAC_INIT,
        // camera sccb takes the pins from here on
        CAM_INIT,
        // both done flags must be high together
        WAIT_ALL,
        RUN
    } seq_state_t;

    // one pin driven as value plus enable
    typedef struct packed {
        logic out;
        // high drives the pad, low leaves it to the pull-up
        logic out_en;
    } mgmt_pin_t;

    // active-low reset releases, one per downstream block
    typedef struct packed {
        // rmii mac and udp stack
        logic mac;
        // sensor and sccb master
        logic cam;
        // frame buffer and udp sender
        logic stream;
        // mjpeg encoder
        logic encoder;
    } rst_bundle_t;

endpackage

//--- status_pkg.sv
`include "cam_params.svh"

package status_pkg;

    // apb request as driven by the host
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        // byte offset inside the status block
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb response from the status block
    typedef struct packed {
        // valid in the access cycle only
        logic [31:0] prdata;
        // no wait states, tied high
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // one window's worth of events
    typedef struct packed {
        logic [`CAM_RATE_CNT_W-1:0] count;
        // single-cycle strobe once count is latched
        logic                       valid;
    } rate_sample_t;

    // note: count holds its value between windows, valid does not

endpackage

//--- bringup_sequencer.sv
`timescale 1ns/1ps

module bringup_sequencer (
    input  logic                     cam_port,
    input  logic                     rst_n,
    input  logic                     i_mac_init_done,
    input  logic                     i_cam_init_done,
    input  bringup_pkg::mgmt_pin_t   i_mac_mdc,
    input  bringup_pkg::mgmt_pin_t   i_mac_mdio,
    input  bringup_pkg::mgmt_pin_t   i_cam_scl,
    input  bringup_pkg::mgmt_pin_t   i_cam_sda,
    output bringup_pkg::mgmt_pin_t   o_scl,
    output bringup_pkg::mgmt_pin_t   o_sda,
    output bringup_pkg::rst_bundle_t o_rst,
    output bringup_pkg::seq_state_t  o_state,
    output logic [3:0]               o_progress_led
);
    import bringup_pkg::*;

    seq_state_t  state_q;
    seq_state_t  state_d;
    rst_bundle_t rst_q;
    logic [3:0]  led_q;
    logic        mac_phase;
    mgmt_pin_t   scl_d;
    mgmt_pin_t   sda_d;
    mgmt_pin_t   scl_q;
    mgmt_pin_t   sda_q;

    // next phase
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // nothing to wait for, leave on the first clock out of reset
                state_d = MAC_INIT;
            end
            MAC_INIT: begin
                if (i_mac_init_done) begin
                    state_d = CAM_INIT;
                end
            end
            CAM_INIT: begin
                if (i_cam_init_done) begin
                    state_d = WAIT_ALL;
                end
            end
            WAIT_ALL: begin
                // mac done may drop during camera init, so check both again
                if (i_mac_init_done && i_cam_init_done) begin
                    state_d = RUN;
                end
            end
            default: begin
                // RUN is terminal
                state_d = state_q;
            end
        endcase
    end

    // state, reset releases and progress leds
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            // everything held in reset
            rst_q   <= '0;
            // all four leds lit
            led_q   <= 4'b1111;
        end else begin
            state_q <= state_d;
            // one led goes dark per step
            if (state_d != state_q) begin
                led_q <= {led_q[2:0], 1'b0};
            end
            // releases are sticky, each set as its phase is entered
            if (state_d == MAC_INIT) begin
                rst_q.mac <= 1'b1;
            end
            if (state_d == CAM_INIT) begin
                rst_q.cam <= 1'b1;
            end
            if (state_d == RUN) begin
                rst_q.stream <= 1'b1;
            end
            // encoder a cycle behind the stream path
            if (state_q == RUN) begin
                rst_q.encoder <= 1'b1;
            end
        end
    end

    // mac owns the shared pins until camera init starts
    assign mac_phase = (state_q == IDLE) || (state_q == MAC_INIT);

    always_comb begin
        if (mac_phase) begin
            // mdc is push-pull, enable always on
            scl_d.out    = i_mac_mdc.out;
            scl_d.out_en = 1'b1;
            sda_d        = i_mac_mdio;
        end else begin
            scl_d = i_cam_scl;
            sda_d = i_cam_sda;
        end
    end

    // pad register, pins float while rst_n is low
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            scl_q <= '0;
            sda_q <= '0;
        end else begin
            scl_q <= scl_d;
            sda_q <= sda_d;
        end
    end

    assign o_scl          = scl_q;
    assign o_sda          = sda_q;
    assign o_rst          = rst_q;
    assign o_state        = state_q;
    assign o_progress_led = led_q;

    // no stray encodings out of the 3-bit state
    a_state_legal: assert property (@(posedge cam_port) disable iff (!rst_n)
        state_q inside {IDLE, MAC_INIT, CAM_INIT, WAIT_ALL, RUN});

    // encoder must never see data before the stream path is live
    a_encoder_after_stream: assert property (@(posedge cam_port) disable iff (!rst_n)
        $rose(rst_q.encoder) |-> rst_q.stream && $past(rst_q.stream));

endmodule

//--- event_rate_monitor.sv
`timescale 1ns/1ps
`include "cam_params.svh"

module event_rate_monitor (
    input  logic                     cam_port,
    input  logic                     rst_n,
    input  logic                     i_event,
    input  logic [31:0]              i_window,
    input  logic                     i_restart,
    output status_pkg::rate_sample_t o_sample,
    output logic                     o_activity_led
);
    import status_pkg::*;

    logic                       event_q;
    logic                       event_rise;
    logic [31:0]                win_cnt_q;
    logic                       win_last;
    logic [`CAM_RATE_CNT_W-1:0] run_cnt_q;
    rate_sample_t               sample_q;
    logic                       led_q;

    // strobe delayed one cycle for edge detect
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            event_q <= 1'b0;
        end else begin
            event_q <= i_event;
        end
    end

    assign event_rise = i_event && !event_q;

    // terminal cycle of the window
    assign win_last = (win_cnt_q == i_window - 32'd1);

    // window counter and running event count
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt_q <= '0;
            run_cnt_q <= '0;
        end else if (i_restart) begin
            // new window length, start over
            win_cnt_q <= '0;
            run_cnt_q <= '0;
        end else if (win_last) begin
            win_cnt_q <= '0;
            // event on the last cycle belongs to the next window
            run_cnt_q <= event_rise ? `CAM_RATE_CNT_W'(1) : '0;
        end else begin
            win_cnt_q <= win_cnt_q + 32'd1;
            if (event_rise) begin
                run_cnt_q <= run_cnt_q + `CAM_RATE_CNT_W'(1);
            end
        end
    end

    // latch at window end
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            sample_q <= '0;
        end else begin
            sample_q.valid <= win_last && !i_restart;
            if (win_last && !i_restart) begin
                sample_q.count <= run_cnt_q;
            end
        end
    end

    // activity led, flips once per counted event
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            led_q <= 1'b1;
        end else if (event_rise) begin
            led_q <= !led_q;
        end
    end

    assign o_sample       = sample_q;
    assign o_activity_led = led_q;

    // valid is a strobe, a window is always longer than one cycle
    a_valid_pulse: assert property (@(posedge cam_port) disable iff (!rst_n)
        sample_q.valid |=> !sample_q.valid);

    // saturating the count would hide a wrap
    a_no_overflow: assert property (@(posedge cam_port) disable iff (!rst_n)
        run_cnt_q != '1);

endmodule

//--- status_regs.sv
`timescale 1ns/1ps
`include "cam_params.svh"

module status_regs (
    input  logic                     cam_port,
    input  logic                     rst_n,
    input  status_pkg::apb_req_t     i_apb,
    output status_pkg::apb_rsp_t     o_apb,
    input  status_pkg::rate_sample_t i_frame_rate,
    input  status_pkg::rate_sample_t i_jpeg_rate,
    input  bringup_pkg::seq_state_t  i_state,
    output logic [31:0]              o_window,
    output logic                     o_restart
);
    logic                       access;
    logic                       wr_window;
    logic                       rd_frame;
    logic                       rd_jpeg;
    logic                       bad_addr;
    logic                       ro_write;
    logic [31:0]                rdata;
    logic [31:0]                window_q;
    logic [`CAM_RATE_CNT_W-1:0] frame_cnt_q;
    logic [`CAM_RATE_CNT_W-1:0] jpeg_cnt_q;
    logic                       frame_new_q;
    logic                       jpeg_new_q;

    // access phase of a transfer
    assign access = i_apb.psel && i_apb.penable;

    assign wr_window = access && i_apb.pwrite && (i_apb.paddr == `CAM_ADDR_WINDOW);
    assign rd_frame  = access && !i_apb.pwrite && (i_apb.paddr == `CAM_ADDR_FRAME_RATE);
    assign rd_jpeg   = access && !i_apb.pwrite && (i_apb.paddr == `CAM_ADDR_JPEG_RATE);

    // read mux and error decode
    always_comb begin
        rdata    = '0;
        bad_addr = 1'b0;
        ro_write = 1'b0;
        case (i_apb.paddr)
            `CAM_ADDR_WINDOW: begin
                rdata = window_q;
            end
            `CAM_ADDR_FRAME_RATE: begin
                rdata[`CAM_RATE_CNT_W-1:0] = frame_cnt_q;
                ro_write                   = i_apb.pwrite;
            end
            `CAM_ADDR_JPEG_RATE: begin
                rdata[`CAM_RATE_CNT_W-1:0] = jpeg_cnt_q;
                ro_write                   = i_apb.pwrite;
            end
            `CAM_ADDR_STATUS: begin
                // state low, sticky flags in the second byte
                rdata[2:0] = i_state;
                rdata[8]   = frame_new_q;
                rdata[9]   = jpeg_new_q;
                ro_write   = i_apb.pwrite;
            end
            default: begin
                bad_addr = 1'b1;
            end
        endcase
    end

    // window register, one second out of reset
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            window_q <= `CAM_RATE_WINDOW_DFLT;
        end else if (wr_window) begin
            window_q <= i_apb.pwdata;
        end
    end

    // latest counts and sticky new flags
    always_ff @(posedge cam_port or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt_q <= '0;
            jpeg_cnt_q  <= '0;
            frame_new_q <= 1'b0;
            jpeg_new_q  <= 1'b0;
        end else begin
            if (i_frame_rate.valid) begin
                frame_cnt_q <= i_frame_rate.count;
            end
            if (i_jpeg_rate.valid) begin
                jpeg_cnt_q <= i_jpeg_rate.count;
            end
            // a fresh sample beats a read in the same cycle
            if (i_frame_rate.valid) begin
                frame_new_q <= 1'b1;
            end else if (rd_frame) begin
                frame_new_q <= 1'b0;
            end
            if (i_jpeg_rate.valid) begin
                jpeg_new_q <= 1'b1;
            end else if (rd_jpeg) begin
                jpeg_new_q <= 1'b0;
            end
        end
    end

    // zero wait states
    assign o_apb.pready  = 1'b1;
    assign o_apb.prdata  = (access && !i_apb.pwrite) ? rdata : '0;
    assign o_apb.pslverr = access && (bad_addr || ro_write);

    assign o_window  = window_q;
    // monitors restart as the new length lands
    assign o_restart = wr_window;

    // access phase only ever follows a select
    a_penable_psel: assert property (@(posedge cam_port) disable iff (!rst_n)
        i_apb.penable |-> i_apb.psel);

endmodule

//--- cam_stream_ctrl.sv
`timescale 1ns/1ps

module cam_stream_ctrl (
    input  logic                     cam_port,
    input  logic                     rst_n,
    input  logic                     i_mac_init_done,
    input  logic                     i_cam_init_done,
    input  bringup_pkg::mgmt_pin_t   i_mac_mdc,
    input  bringup_pkg::mgmt_pin_t   i_mac_mdio,
    input  bringup_pkg::mgmt_pin_t   i_cam_scl,
    input  bringup_pkg::mgmt_pin_t   i_cam_sda,
    input  logic                     i_cam_vsync,
    input  logic                     i_jpeg_done,
    input  status_pkg::apb_req_t     i_apb,
    output status_pkg::apb_rsp_t     o_apb,
    output bringup_pkg::mgmt_pin_t   o_scl,
    output bringup_pkg::mgmt_pin_t   o_sda,
    output bringup_pkg::rst_bundle_t o_rst,
    output logic [5:0]               o_led
);
    import bringup_pkg::*;
    import status_pkg::*;

    seq_state_t   seq_state;
    rate_sample_t frame_rate;
    rate_sample_t jpeg_rate;
    logic [31:0]  window;
    logic         restart;
    logic [3:0]   progress_led;
    logic         frame_led;
    logic         jpeg_led;

    // power-up ordering and shared pin ownership
    bringup_sequencer u_sequencer (
        .cam_port        (cam_port),
        .rst_n           (rst_n),
        .i_mac_init_done (i_mac_init_done),
        .i_cam_init_done (i_cam_init_done),
        .i_mac_mdc       (i_mac_mdc),
        .i_mac_mdio      (i_mac_mdio),
        .i_cam_scl       (i_cam_scl),
        .i_cam_sda       (i_cam_sda),
        .o_scl           (o_scl),
        .o_sda           (o_sda),
        .o_rst           (o_rst),
        .o_state         (seq_state),
        .o_progress_led  (progress_led)
    );

    // camera frame starts, counted on vsync rise
    event_rate_monitor u_frame_rate (
        .cam_port       (cam_port),
        .rst_n          (rst_n),
        .i_event        (i_cam_vsync),
        .i_window       (window),
        .i_restart      (restart),
        .o_sample       (frame_rate),
        .o_activity_led (frame_led)
    );

    // encoder frame completions
    event_rate_monitor u_jpeg_rate (
        .cam_port       (cam_port),
        .rst_n          (rst_n),
        .i_event        (i_jpeg_done),
        .i_window       (window),
        .i_restart      (restart),
        .o_sample       (jpeg_rate),
        .o_activity_led (jpeg_led)
    );

    status_regs u_status (
        .cam_port     (cam_port),
        .rst_n        (rst_n),
        .i_apb        (i_apb),
        .o_apb        (o_apb),
        .i_frame_rate (frame_rate),
        .i_jpeg_rate  (jpeg_rate),
        .i_state      (seq_state),
        .o_window     (window),
        .o_restart    (restart)
    );

    // board leds, frame activity on top
    assign o_led = {frame_led, jpeg_led, progress_led};

endmodule

//--- tb_cam_stream_ctrl.sv
`timescale 1ns/1ps
`include "cam_params.svh"

module tb_cam_stream_ctrl;
    import bringup_pkg::*;
    import status_pkg::*;

    localparam int N_ROWS = 5;

    logic        cam_port;
    logic        rst_n;
    logic        i_mac_init_done;
    logic        i_cam_init_done;
    mgmt_pin_t   i_mac_mdc;
    mgmt_pin_t   i_mac_mdio;
    mgmt_pin_t   i_cam_scl;
    mgmt_pin_t   i_cam_sda;
    logic        i_cam_vsync;
    logic        i_jpeg_done;
    apb_req_t    i_apb;
    apb_rsp_t    o_apb;
    mgmt_pin_t   o_scl;
    mgmt_pin_t   o_sda;
    rst_bundle_t o_rst;
    logic [5:0]  o_led;

    // per row the window length, vsync and jpeg pulses and expected counts
    int unsigned row_window[N_ROWS]    = '{100, 120, 80, 200, 64};
    int unsigned row_vsync[N_ROWS]     = '{5, 12, 0, 20, 2};
    int unsigned row_jpeg[N_ROWS]      = '{3, 7, 4, 1, 2};
    int unsigned row_exp_frame[N_ROWS] = '{5, 12, 0, 20, 2};
    int unsigned row_exp_jpeg[N_ROWS]  = '{3, 7, 4, 1, 2};

    int          n_mismatch;
    int          n_failure;
    int          cycle_cnt;
    logic [31:0] rng;

    cam_stream_ctrl cam_stream_ctrl_i (.*);

    initial begin
        cam_port = 1'b0;
        forever #5 cam_port = ~cam_port;
    end

    // free cycle count bumped away from the drive edge
    always @(negedge cam_port) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        n_mismatch++;
        $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        n_failure++;
        $display("failure at %0t ns: %s", $time, what);
    endtask

    // setup cycle with psel up and penable low
    task automatic apb_setup(input logic wr, input logic [7:0] addr, input logic [31:0] wdata);
        @(posedge cam_port);
        i_apb.psel    <= 1'b1;
        i_apb.penable <= 1'b0;
        i_apb.pwrite  <= wr;
        i_apb.paddr   <= addr;
        i_apb.pwdata  <= wdata;
    endtask

    // access cycle with the response sampled mid-cycle
    task automatic apb_access(output logic [31:0] rdata, output logic slverr);
        @(posedge cam_port);
        i_apb.penable <= 1'b1;
        @(negedge cam_port);
        rdata  = o_apb.prdata;
        slverr = o_apb.pslverr;
        if (o_apb.pready !== 1'b1) begin
            report_mismatch("o_apb.pready", o_apb.pready, 1'b1);
        end
        @(posedge cam_port);
        i_apb <= '0;
    endtask

    task automatic bus_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic slverr);
        apb_setup(wr, addr, wdata);
        apb_access(rdata, slverr);
    endtask

    task automatic wait_outputs(input logic [3:0] exp_led, input logic [3:0] exp_rst);
        int waited;
        waited = 0;
        @(negedge cam_port);
        while ((o_led[3:0] !== exp_led || o_rst !== exp_rst) && waited < 50) begin
            @(negedge cam_port);
            waited++;
        end
        if (o_led[3:0] !== exp_led || o_rst !== exp_rst) begin
            report_failure($sformatf("progress leds never reached %b with resets %b",
                                     exp_led, exp_rst));
        end
    endtask

    // poll status until both monitors flag a fresh sample
    task automatic wait_new_flags();
        logic [31:0] rdata;
        logic        slverr;
        int          tries;
        tries = 0;
        rdata = '0;
        while (rdata[9:8] !== 2'b11 && tries < 300) begin
            bus_transfer(1'b0, `CAM_ADDR_STATUS, '0, rdata, slverr);
            tries++;
        end
        if (rdata[9:8] !== 2'b11) begin
            report_failure("status new bits never set after the window ended");
        end
    endtask

    // single-cycle pulses with random low gaps of one to four cycles
    task automatic drive_pulses(input int n_vsync, input int n_jpeg);
        int i;
        int gap;
        int n_max;
        n_max = (n_vsync > n_jpeg) ? n_vsync : n_jpeg;
        for (i = 0; i < n_max; i++) begin
            @(posedge cam_port);
            i_cam_vsync <= (i < n_vsync);
            i_jpeg_done <= (i < n_jpeg);
            @(posedge cam_port);
            i_cam_vsync <= 1'b0;
            i_jpeg_done <= 1'b0;
            rng = xorshift32(rng);
            gap = rng % 4;
            repeat (gap) @(posedge cam_port);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        slverr;
        logic [3:0]  pins;
        logic        exp_frame_led;
        logic        exp_jpeg_led;
        int          win_start;
        int          r;
        int          k;
        n_mismatch      = 0;
        n_failure       = 0;
        cycle_cnt       = 0;
        rng             = 32'haf82;
        rst_n           = 1'b0;
        i_mac_init_done = 1'b0;
        i_cam_init_done = 1'b0;
        i_mac_mdc       = '0;
        i_mac_mdio      = '0;
        i_cam_scl       = '0;
        i_cam_sda       = '0;
        i_cam_vsync     = 1'b0;
        i_jpeg_done     = 1'b0;
        i_apb           = '0;
        exp_frame_led   = 1'b1;
        exp_jpeg_led    = 1'b1;

        // everything held, pads off, all leds lit
        @(posedge cam_port);
        @(negedge cam_port);
        if (o_rst !== 4'b0000) report_mismatch("o_rst", o_rst, 4'b0000);
        if (o_scl.out_en !== 1'b0) report_mismatch("o_scl.out_en", o_scl.out_en, 1'b0);
        if (o_sda.out_en !== 1'b0) report_mismatch("o_sda.out_en", o_sda.out_en, 1'b0);
        if (o_led !== 6'b111111) report_mismatch("o_led", o_led, 6'b111111);
        @(posedge cam_port);
        rst_n <= 1'b1;

        // mdc enable is forced on in the mac phase
        for (k = 0; k < 4; k++) begin
            rng  = xorshift32(rng);
            pins = rng[3:0];
            @(posedge cam_port);
            i_mac_mdc  <= {pins[1], 1'b0};
            i_mac_mdio <= pins[3:2];
            @(posedge cam_port);
            @(negedge cam_port);
            if (o_scl !== {pins[1], 1'b1}) report_mismatch("o_scl", o_scl, {pins[1], 1'b1});
            if (o_sda !== pins[3:2]) report_mismatch("o_sda", o_sda, pins[3:2]);
        end
        if (o_led !== 6'b111110) report_mismatch("o_led", o_led, 6'b111110);
        if (o_rst !== 4'b1000) report_mismatch("o_rst", o_rst, 4'b1000);

        // walk the phases up to run
        @(posedge cam_port);
        i_mac_init_done <= 1'b1;
        wait_outputs(4'b1100, 4'b1100);
        @(posedge cam_port);
        i_cam_init_done <= 1'b1;
        wait_outputs(4'b1000, 4'b1100);
        wait_outputs(4'b0000, 4'b1111);
        bus_transfer(1'b0, `CAM_ADDR_STATUS, '0, rdata, slverr);
        if (rdata[2:0] !== 3'(RUN)) report_mismatch("status state", rdata[2:0], 3'(RUN));
        if (slverr !== 1'b0) report_mismatch("o_apb.pslverr", slverr, 1'b0);

        // camera owns both pins now
        for (k = 0; k < 6; k++) begin
            rng  = xorshift32(rng);
            pins = rng[3:0];
            @(posedge cam_port);
            i_cam_scl <= pins[1:0];
            i_cam_sda <= pins[3:2];
            @(posedge cam_port);
            @(negedge cam_port);
            if (o_scl !== pins[1:0]) report_mismatch("o_scl", o_scl, pins[1:0]);
            if (o_sda !== pins[3:2]) report_mismatch("o_sda", o_sda, pins[3:2]);
        end

        for (r = 0; r < N_ROWS; r++) begin
            // new length restarts both windows
            bus_transfer(1'b1, `CAM_ADDR_WINDOW, row_window[r], rdata, slverr);
            win_start = cycle_cnt;
            if (slverr !== 1'b0) report_mismatch("o_apb.pslverr", slverr, 1'b0);
            // drop flags left from older windows
            bus_transfer(1'b0, `CAM_ADDR_FRAME_RATE, '0, rdata, slverr);
            bus_transfer(1'b0, `CAM_ADDR_JPEG_RATE, '0, rdata, slverr);
            bus_transfer(1'b0, `CAM_ADDR_WINDOW, '0, rdata, slverr);
            if (rdata !== row_window[r]) report_mismatch("window", rdata, row_window[r]);
            drive_pulses(row_vsync[r], row_jpeg[r]);
            if (cycle_cnt - win_start >= row_window[r] - 4) begin
                report_failure($sformatf("pulses of row %0d ran past the window end", r));
            end
            exp_frame_led = exp_frame_led ^ row_vsync[r][0];
            exp_jpeg_led  = exp_jpeg_led ^ row_jpeg[r][0];
            wait_new_flags();
            bus_transfer(1'b0, `CAM_ADDR_FRAME_RATE, '0, rdata, slverr);
            if (rdata !== row_exp_frame[r]) begin
                report_mismatch("frame rate", rdata, row_exp_frame[r]);
            end
            // frame read drops bit 8 and leaves the jpeg flag in bit 9
            bus_transfer(1'b0, `CAM_ADDR_STATUS, '0, rdata, slverr);
            if (rdata[9:8] !== 2'b10) report_mismatch("status new bits", rdata[9:8], 2'b10);
            bus_transfer(1'b0, `CAM_ADDR_JPEG_RATE, '0, rdata, slverr);
            if (rdata !== row_exp_jpeg[r]) begin
                report_mismatch("jpeg rate", rdata, row_exp_jpeg[r]);
            end
            // both reads clear their flags
            bus_transfer(1'b0, `CAM_ADDR_STATUS, '0, rdata, slverr);
            if (rdata[9:8] !== 2'b00) report_mismatch("status new bits", rdata[9:8], 2'b00);
            if (o_led[5] !== exp_frame_led) begin
                report_mismatch("o_led[5]", o_led[5], exp_frame_led);
            end
            if (o_led[4] !== exp_jpeg_led) begin
                report_mismatch("o_led[4]", o_led[4], exp_jpeg_led);
            end
        end

        // unmapped read and read-only write
        bus_transfer(1'b0, 8'h10, '0, rdata, slverr);
        if (slverr !== 1'b1) report_mismatch("o_apb.pslverr", slverr, 1'b1);
        bus_transfer(1'b1, `CAM_ADDR_FRAME_RATE, 32'h1234, rdata, slverr);
        if (slverr !== 1'b1) report_mismatch("o_apb.pslverr", slverr, 1'b1);

        $display("done: %0d mismatches, %0d other failures", n_mismatch, n_failure);
        if (n_mismatch == 0 && n_failure == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
bringup_pkg.sv
status_pkg.sv
bringup_sequencer.sv
event_rate_monitor.sv
status_regs.sv
cam_stream_ctrl.sv
tb_cam_stream_ctrl.sv
